/* files.f */
+incdir+design
+incdir+dv
design/fetch_pkg.sv
design/branch_target_buffer.sv
design/local_history_predictor.sv
design/resolve_queue.sv
design/fetch_ctrl.sv
design/fetch_top.sv
dv/fetch_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = fetch_tb
FILELIST = files.f
LOG      = sim.log
PASS     = Test completed successfully

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/fetch_model.svh */
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// expected fetch state after each clock edge
logic [`FETCH_XLEN-1:0] m_pc;
logic                   m_valid;
logic [`FETCH_XLEN-1:0] m_out_pc;
logic                   m_out_pred;
logic                   m_flush;
logic                   m_btb_valid [16];
logic [25:0]            m_btb_tag [16];
logic [`FETCH_XLEN-1:0] m_btb_target [16];
logic [3:0]             m_lht [16];
logic [1:0]             m_pht [16];
pred_entry_t            m_q [$];       // in-flight control transfers
logic [`FETCH_XLEN-1:0] m_q_tgt [$];   // target seen in the btb at fetch

task automatic reset_model();
  m_pc       = `FETCH_RESET_PC;
  m_valid    = 1'b0;
  m_out_pc   = '0;
  m_out_pred = 1'b0;
  m_flush    = 1'b0;
  m_q.delete();
  m_q_tgt.delete();
  for (int i = 0; i < 16; i++)
  begin
    m_btb_valid[i]  = 1'b0;
    m_btb_tag[i]    = '0;
    m_btb_target[i] = '0;
    m_lht[i]        = '0;
    m_pht[i]        = 2'b00;
  end
endtask

// advance the model over one edge with the inputs driven for it
task automatic step_model(input logic ready, input logic rv, input logic rtaken,
                          input logic [`FETCH_XLEN-1:0] rtarget);
  logic [`FETCH_XLEN-1:0] instr;
  logic [`FETCH_XLEN-1:0] btgt;
  logic [`FETCH_XLEN-1:0] head_tgt;
  logic [3:0]             idx;
  logic [3:0]             hist;
  logic                   is_br;
  logic                   is_jmp;
  logic                   guess;
  logic                   rfire;
  logic                   mis;
  logic                   fire;
  pred_entry_t            head;
  pred_entry_t            entry;
  instr  = program_word(m_pc);
  is_br  = (instr[6:0] == `FETCH_OP_BRANCH);
  is_jmp = (instr[6:0] == `FETCH_OP_JAL) || (instr[6:0] == `FETCH_OP_JALR);
  idx    = m_pc[5:2];
  btgt   = m_btb_target[idx];
  guess  = m_btb_valid[idx] && (m_btb_tag[idx] == m_pc[31:6]) &&
           (is_jmp || (is_br && m_pht[m_lht[idx]][1]));
  rfire  = rv && (m_q.size() > 0);
  mis    = 1'b0;
  head   = '0;
  if (rfire)
  begin
    head     = m_q.pop_front();
    head_tgt = m_q_tgt.pop_front();
    mis = (rtaken != head.pred_taken) || (rtaken && (rtarget != head_tgt));
  end
  fire = (!m_valid || ready) && !((is_br || is_jmp) && (m_q.size() + (rfire ? 1 : 0) ==
         `FETCH_QUEUE_DEPTH)) && !mis;
  if (rfire)  // train only after the lookup above
  begin
    idx = head.pc[5:2];
    if (rtaken)
    begin
      m_btb_valid[idx]  = 1'b1;
      m_btb_tag[idx]    = head.pc[31:6];
      m_btb_target[idx] = rtarget;
    end
    if (head.is_cond)
    begin
      hist = m_lht[idx];
      if (rtaken && m_pht[hist] != 2'b11)
        m_pht[hist] = m_pht[hist] + 2'd1;
      else if (!rtaken && m_pht[hist] != 2'b00)
        m_pht[hist] = m_pht[hist] - 2'd1;
      m_lht[idx] = {rtaken, hist[3:1]};
    end
  end
  if (mis)
  begin
    m_q.delete();
    m_q_tgt.delete();
    m_pc    = rtaken ? rtarget : head.pc + 32'd4;
    m_valid = 1'b0;
  end
  else if (fire)
  begin
    if (is_br || is_jmp)
    begin
      entry = '{pc: m_pc, pred_taken: guess, is_cond: is_br};
      m_q.push_back(entry);
      m_q_tgt.push_back(btgt);
    end
    m_out_pc   = m_pc;
    m_out_pred = guess;
    m_valid    = 1'b1;
    m_pc       = guess ? btgt : m_pc + 32'd4;
  end
  else if (ready)
    m_valid = 1'b0;
  m_flush = mis;
endtask

`endif

/* dv/fetch_tb.sv */
`default_nettype none

`include "fetch_config.svh"

module fetch_tb;

  import fetch_pkg::*;

  logic                   clk;
  logic                   rst;
  logic [`FETCH_XLEN-1:0] imem_addr;
  logic [`FETCH_XLEN-1:0] imem_data;
  logic                   out_valid;
  fetch_out_t             out_data;
  logic                   out_ready;
  logic                   resolve_valid;
  resolve_t               resolve_data;
  logic                   flush;

  logic                   row_ready [$];
  logic                   row_resolve [$];
  logic                   row_taken [$];
  logic [`FETCH_XLEN-1:0] row_target [$];
  string                  row_label [$];
  integer                 seed = 32'h3924;
  int                     errors = 0;
  int                     checks = 0;

  // small program with a branch at 0x20, jal at 0x40, jalr at 0x90
  function automatic logic [`FETCH_XLEN-1:0] program_word(input logic [`FETCH_XLEN-1:0] addr);
    case (addr)
      32'h20:  return {25'd0, `FETCH_OP_BRANCH};
      32'h40:  return {25'd0, `FETCH_OP_JAL};
      32'h90:  return {25'd0, `FETCH_OP_JALR};
      default: return {addr[31:7] ^ addr[24:0], 7'b0010011};  // op-imm filler
    endcase
  endfunction

  `include "fetch_model.svh"

  fetch_top i_dut (
    .clk           (clk),
    .rst           (rst),
    .imem_addr     (imem_addr),
    .imem_data     (imem_data),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_ready     (out_ready),
    .resolve_valid (resolve_valid),
    .resolve_data  (resolve_data),
    .flush         (flush)
  );

  assign imem_data = program_word(imem_addr);  // same-cycle answer

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ready mode 0 high, 1 low, 2 random
  task automatic add_rows(input int n, input int mode, input int every, input logic taken,
                          input logic [`FETCH_XLEN-1:0] target, input string label);
    int r;
    for (int i = 0; i < n; i++)
    begin
      r = $random(seed);
      row_ready.push_back(mode == 0 ? 1'b1 : (mode == 1 ? 1'b0 : (r[1:0] != 2'b00)));
      row_resolve.push_back(every > 0 && (i % every == every - 1));
      row_taken.push_back(taken);
      row_target.push_back(target);
      row_label.push_back(label);
    end
  endtask

  task automatic compare_outputs(input string label);
    checks++;
    assert (out_valid === m_valid && flush === m_flush && imem_addr === m_pc)
    else
    begin
      errors++;
      $display("error %0t: %s control mismatch valid %b/%b flush %b/%b pc %h/%h", $time,
               label, out_valid, m_valid, flush, m_flush, imem_addr, m_pc);
    end
    if (m_valid)
    begin
      checks++;
      assert (out_data.pc === m_out_pc && out_data.pred_taken === m_out_pred &&
              out_data.instr === program_word(m_out_pc))
      else
      begin
        errors++;
        $display("error %0t: %s output pc %h/%h pred %b/%b", $time, label,
                 out_data.pc, m_out_pc, out_data.pred_taken, m_out_pred);
      end
    end
  endtask

  initial
  begin
    rst           = 1'b1;
    out_ready     = 1'b0;
    resolve_valid = 1'b0;
    resolve_data  = '0;
    add_rows(8, 0, 0, 1'b0, 32'h0, "straight");
    add_rows(96, 0, 4, 1'b1, 32'h10, "loop_train");
    add_rows(6, 1, 0, 1'b0, 32'h0, "ready_low");
    add_rows(40, 2, 6, 1'b1, 32'h10, "random_ready");
    add_rows(50, 0, 0, 1'b0, 32'h0, "queue_fill");
    add_rows(40, 0, 2, 1'b1, 32'h10, "drain");
    add_rows(1, 0, 1, 1'b0, 32'h0, "loop_exit");
    add_rows(14, 0, 0, 1'b0, 32'h0, "to_jal");
    add_rows(1, 0, 1, 1'b1, 32'h80, "jal_resolve");
    add_rows(14, 0, 0, 1'b0, 32'h0, "to_jalr");
    add_rows(1, 0, 1, 1'b1, 32'h0, "jalr_resolve");
    add_rows(12, 0, 0, 1'b0, 32'h0, "rerun");
    add_rows(1, 0, 1, 1'b0, 32'h0, "second_exit");
    add_rows(16, 0, 0, 1'b0, 32'h0, "jal_miss");
    add_rows(1, 0, 1, 1'b1, 32'h80, "jal_ok");
    add_rows(21, 0, 0, 1'b0, 32'h0, "to_jal_hit");
    add_rows(1, 0, 0, 1'b0, 32'h0, "jal_hit");
    add_rows(1, 0, 1, 1'b1, 32'h100, "jalr_new");
    add_rows(20, 0, 0, 1'b0, 32'h0, "after_jalr");
    add_rows(8, 0, 3, 1'b0, 32'h0, "empty_resolve");
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_model();
    for (int i = 0; i < row_ready.size(); i++)
    begin
      out_ready          = row_ready[i];
      resolve_valid      = row_resolve[i];
      resolve_data.taken  = row_taken[i];
      resolve_data.target = row_target[i];
      step_model(row_ready[i], row_resolve[i], row_taken[i], row_target[i]);
      @(posedge clk);
      #1;  // outputs settled after the edge
      compare_outputs(row_label[i]);
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // watchdog sized from the table
  initial
  begin
    #1;
    repeat (row_ready.size() * 20) @(posedge clk);
    $display("watchdog expired before the stimulus table finished");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* design/fetch_top.sv */
`default_nettype none

`include "fetch_config.svh"

module fetch_top (
  input  logic                   clk,
  input  logic                   rst,
  output logic [`FETCH_XLEN-1:0] imem_addr,
  input  logic [`FETCH_XLEN-1:0] imem_data,
  output logic                   out_valid,
  output fetch_pkg::fetch_out_t  out_data,
  input  logic                   out_ready,
  input  logic                   resolve_valid,
  input  fetch_pkg::resolve_t    resolve_data,
  output logic                   flush
);

  import fetch_pkg::*;

  logic [`FETCH_XLEN-1:0] lookup_pc;
  logic                   btb_hit;
  logic [`FETCH_XLEN-1:0] btb_target;
  logic                   pred_taken;
  logic                   q_push;
  pred_entry_t            q_push_data;
  logic                   q_pop;
  logic                   q_clear;
  pred_entry_t            q_head;
  logic                   q_empty;
  logic                   q_full;
  logic                   train_valid;
  bp_update_t             train_data;

  fetch_ctrl i_ctrl (
    .clk           (clk),
    .rst           (rst),
    .imem_addr     (imem_addr),
    .imem_data     (imem_data),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_ready     (out_ready),
    .resolve_valid (resolve_valid),
    .resolve_data  (resolve_data),
    .lookup_pc     (lookup_pc),
    .btb_hit       (btb_hit),
    .btb_target    (btb_target),
    .pred_taken    (pred_taken),
    .q_push        (q_push),
    .q_push_data   (q_push_data),
    .q_pop         (q_pop),
    .q_clear       (q_clear),
    .q_head        (q_head),
    .q_empty       (q_empty),
    .q_full        (q_full),
    .train_valid   (train_valid),
    .train_data    (train_data),
    .flush         (flush)
  );

  branch_target_buffer i_btb (
    .clk         (clk),
    .rst         (rst),
    .lookup_pc   (lookup_pc),
    .hit         (btb_hit),
    .target      (btb_target),
    .train_valid (train_valid),
    .train_data  (train_data)
  );

  local_history_predictor i_pred (
    .clk         (clk),
    .rst         (rst),
    .lookup_pc   (lookup_pc),
    .pred_taken  (pred_taken),
    .train_valid (train_valid),
    .train_data  (train_data)
  );

  resolve_queue #(
    .payload_t (pred_entry_t),
    .depth     (`FETCH_QUEUE_DEPTH)
  ) i_queue (
    .clk       (clk),
    .rst       (rst),
    .push      (q_push),
    .push_data (q_push_data),
    .pop       (q_pop),
    .clear     (q_clear),
    .head      (q_head),
    .empty     (q_empty),
    .full      (q_full)
  );

endmodule

`default_nettype wire

/* design/fetch_ctrl.sv */
`default_nettype none

`include "fetch_config.svh"

module fetch_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  output logic [`FETCH_XLEN-1:0] imem_addr,
  input  logic [`FETCH_XLEN-1:0] imem_data,
  output logic                   out_valid,
  output fetch_pkg::fetch_out_t  out_data,
  input  logic                   out_ready,
  input  logic                   resolve_valid,
  input  fetch_pkg::resolve_t    resolve_data,
  output logic [`FETCH_XLEN-1:0] lookup_pc,
  input  logic                   btb_hit,
  input  logic [`FETCH_XLEN-1:0] btb_target,
  input  logic                   pred_taken,
  output logic                   q_push,
  output fetch_pkg::pred_entry_t q_push_data,
  output logic                   q_pop,
  output logic                   q_clear,
  input  fetch_pkg::pred_entry_t q_head,
  input  logic                   q_empty,
  input  logic                   q_full,
  output logic                   train_valid,
  output fetch_pkg::bp_update_t  train_data,
  output logic                   flush
);

  localparam int qptr_w = (`FETCH_QUEUE_DEPTH > 1) ? $clog2(`FETCH_QUEUE_DEPTH) : 1;
  localparam logic [`FETCH_XLEN-1:0] instr_bytes = 4;

  logic [`FETCH_XLEN-1:0] pc;
  logic [6:0]             opcode;
  logic                   is_branch;
  logic                   is_jump;
  logic                   is_ctrl;
  logic                   taken_guess;
  logic [`FETCH_XLEN-1:0] pred_next_pc;
  logic [`FETCH_XLEN-1:0] fix_pc;
  logic                   out_free;
  logic                   ctrl_stall;
  logic                   fetch_fire;
  logic                   resolve_fire;
  logic                   mispredict;
  logic [`FETCH_XLEN-1:0] tgt_mem [`FETCH_QUEUE_DEPTH];
  logic [qptr_w-1:0]      tgt_wr;
  logic [qptr_w-1:0]      tgt_rd;

  assign imem_addr = pc;
  assign lookup_pc = pc;  // btb and predictor see the same pc

  // predecode
  assign opcode    = imem_data[6:0];
  assign is_branch = (opcode == `FETCH_OP_BRANCH);
  assign is_jump   = (opcode == `FETCH_OP_JAL) || (opcode == `FETCH_OP_JALR);
  assign is_ctrl   = is_branch || is_jump;

  // jumps go on any hit, branches also need the counter
  assign taken_guess  = btb_hit && (is_jump || (is_branch && pred_taken));
  assign pred_next_pc = taken_guess ? btb_target : pc + instr_bytes;

  assign out_free   = !out_valid || out_ready;
  assign ctrl_stall = is_ctrl && q_full;  // no room to remember it
  assign fetch_fire = out_free && !ctrl_stall && !mispredict;

  assign resolve_fire = resolve_valid && !q_empty;  // empty queue ignores resolve
  assign mispredict   = resolve_fire &&
                        ((resolve_data.taken != q_head.pred_taken) ||
                         (resolve_data.taken && (resolve_data.target != tgt_mem[tgt_rd])));
  assign fix_pc       = resolve_data.taken ? resolve_data.target : q_head.pc + instr_bytes;

  assign q_push      = fetch_fire && is_ctrl;
  assign q_push_data = '{pc: pc, pred_taken: taken_guess, is_cond: is_branch};
  assign q_pop       = resolve_fire;
  assign q_clear     = mispredict;

  assign train_valid = resolve_fire;
  assign train_data  = '{pc: q_head.pc, taken: resolve_data.taken,
                         target: resolve_data.target, is_cond: q_head.is_cond};

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pc        <= `FETCH_RESET_PC;
      out_valid <= 1'b0;
      flush     <= 1'b0;
    end
    else
    begin
      flush <= mispredict;  // one cycle pulse
      if (mispredict)
      begin
        pc        <= fix_pc;
        out_valid <= 1'b0;  // drop the wrong-path instruction
      end
      else if (fetch_fire)
      begin
        pc        <= pred_next_pc;
        out_valid <= 1'b1;
      end
      else if (out_ready)
        out_valid <= 1'b0;  // taken by decode, nothing new behind it
    end
  end

  always_ff @(posedge clk)
  begin
    if (fetch_fire)
      out_data <= '{pc: pc, instr: imem_data, pred_taken: taken_guess};
  end

  // predicted targets, kept in step with the resolve queue
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      tgt_wr <= '0;
      tgt_rd <= '0;
    end
    else if (q_clear)
    begin
      tgt_wr <= '0;
      tgt_rd <= '0;
    end
    else
    begin
      if (q_push)
        tgt_wr <= (tgt_wr == qptr_w'(`FETCH_QUEUE_DEPTH - 1)) ? '0 : tgt_wr + 1'b1;
      if (q_pop)
        tgt_rd <= (tgt_rd == qptr_w'(`FETCH_QUEUE_DEPTH - 1)) ? '0 : tgt_rd + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (q_push)
      tgt_mem[tgt_wr] <= btb_target;
  end

endmodule

`default_nettype wire

/* design/resolve_queue.sv */
`default_nettype none

`include "fetch_config.svh"

module resolve_queue #(
  parameter type payload_t = logic [`FETCH_XLEN-1:0],
  parameter int  depth     = `FETCH_QUEUE_DEPTH
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  input  logic     clear,
  output payload_t head,
  output logic     empty,
  output logic     full
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign empty   = (count == '0);
  assign full    = (count == cnt_w'(depth));
  assign head    = mem[rd_ptr];  // oldest entry

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)
        rd_ptr <= next_ptr(rd_ptr);
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

endmodule

`default_nettype wire

/* design/local_history_predictor.sv */
`default_nettype none

`include "fetch_config.svh"

module local_history_predictor (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`FETCH_XLEN-1:0] lookup_pc,
  output logic                   pred_taken,
  input  logic                   train_valid,
  input  fetch_pkg::bp_update_t  train_data
);

  localparam int lht_size = 1 << `FETCH_LHT_INDEX_W;
  localparam int pht_size = 1 << `FETCH_HIST_W;

  logic [`FETCH_HIST_W-1:0]      lht [lht_size];  // per-branch history
  logic [1:0]                    pht [pht_size];  // 2-bit saturating counters
  logic [`FETCH_LHT_INDEX_W-1:0] rd_idx;
  logic [`FETCH_LHT_INDEX_W-1:0] wr_idx;
  logic [`FETCH_HIST_W-1:0]      rd_hist;
  logic [`FETCH_HIST_W-1:0]      wr_hist;
  logic [1:0]                    wr_ctr;
  logic                          wr_en;

  assign rd_idx     = lookup_pc[`FETCH_LHT_INDEX_W+1:2];
  assign rd_hist    = lht[rd_idx];
  assign pred_taken = pht[rd_hist][1];  // weakly or strongly taken

  assign wr_idx  = train_data.pc[`FETCH_LHT_INDEX_W+1:2];
  assign wr_hist = lht[wr_idx];
  assign wr_ctr  = pht[wr_hist];
  assign wr_en   = train_valid && train_data.is_cond;  // jumps leave history alone

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < lht_size; i++)
        lht[i] <= '0;
      for (int j = 0; j < pht_size; j++)
        pht[j] <= 2'b00;
    end
    else if (wr_en)
    begin
      if (train_data.taken)
      begin
        if (wr_ctr != 2'b11)
          pht[wr_hist] <= wr_ctr + 2'd1;
      end
      else if (wr_ctr != 2'b00)
        pht[wr_hist] <= wr_ctr - 2'd1;
      // newest outcome enters at the top
      lht[wr_idx] <= {train_data.taken, wr_hist[`FETCH_HIST_W-1:1]};
    end
  end

endmodule

`default_nettype wire

/* design/branch_target_buffer.sv */
`default_nettype none

`include "fetch_config.svh"

module branch_target_buffer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`FETCH_XLEN-1:0] lookup_pc,
  output logic                   hit,
  output logic [`FETCH_XLEN-1:0] target,
  input  logic                   train_valid,
  input  fetch_pkg::bp_update_t  train_data
);

  localparam int entries = 1 << `FETCH_BTB_INDEX_W;
  localparam int tag_w   = `FETCH_XLEN - `FETCH_BTB_INDEX_W - 2;

  logic [entries-1:0]            valid;
  logic [tag_w-1:0]              tag_mem [entries];
  logic [`FETCH_XLEN-1:0]        target_mem [entries];
  logic [`FETCH_BTB_INDEX_W-1:0] rd_idx;
  logic [`FETCH_BTB_INDEX_W-1:0] wr_idx;
  logic [tag_w-1:0]              rd_tag;
  logic [tag_w-1:0]              wr_tag;
  logic                          wr_en;

  // word aligned pc, so bits 1:0 are skipped
  assign rd_idx = lookup_pc[`FETCH_BTB_INDEX_W+1:2];
  assign rd_tag = lookup_pc[`FETCH_XLEN-1:`FETCH_BTB_INDEX_W+2];
  assign wr_idx = train_data.pc[`FETCH_BTB_INDEX_W+1:2];
  assign wr_tag = train_data.pc[`FETCH_XLEN-1:`FETCH_BTB_INDEX_W+2];

  assign wr_en = train_valid && train_data.taken;  // only taken outcomes carry a target

  assign hit    = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign target = target_mem[rd_idx];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      valid <= '0;
    else if (wr_en)
      valid[wr_idx] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      tag_mem[wr_idx]    <= wr_tag;
      target_mem[wr_idx] <= train_data.target;
    end
  end

endmodule

`default_nettype wire

/* design/fetch_pkg.sv */
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

  // one fetched instruction, handed to decode
  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] instr;
    logic                   pred_taken;  // fetch followed the btb target
  } fetch_out_t;

  // execute stage outcome for the oldest control transfer
  typedef struct packed {
    logic                   taken;
    logic [`FETCH_XLEN-1:0] target;      // only meaningful when taken
  } resolve_t;

  // what the resolve queue keeps per control transfer
  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
    logic                   pred_taken;
    logic                   is_cond;     // conditional branch, not a jump
  } pred_entry_t;

  // training write to btb and predictor
  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
    logic                   taken;
    logic [`FETCH_XLEN-1:0] target;
    logic                   is_cond;     // predictor only trains on these
  } bp_update_t;

endpackage

`default_nettype wire

/* design/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// address and instruction width
`define FETCH_XLEN 32

// btb index bits, taken from pc[5:2]
`define FETCH_BTB_INDEX_W 4

// local history length, also sets the counter count
`define FETCH_HIST_W 4

// history table index bits, taken from pc[5:2]
`define FETCH_LHT_INDEX_W 4

// in-flight control transfers
`define FETCH_QUEUE_DEPTH 8

// rv32 opcodes seen by predecode
`define FETCH_OP_BRANCH 7'b1100011
`define FETCH_OP_JAL    7'b1101111
`define FETCH_OP_JALR   7'b1100111

`define FETCH_RESET_PC 32'h0000_0000

`endif
